// File: filelist.f
heapPkg.sv
stageResultIf.sv
arrayAllocator.sv
arrayStore.sv
responseMerge.sv
arrayHeap.sv
arrayHeap_assertions.sv
arrayHeap_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the array heap testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
  --top-module arrayHeap_tb --Mdir obj_dir -o arrayHeapSim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Build failed"
  exit 1
fi

./obj_dir/arrayHeapSim +verilator+error+limit+100 > sim.log 2>&1
simStatus=$?
cat sim.log

if grep -q "Test FAILED" sim.log; then
  exit 1
fi
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi
exit 0

// File: arrayHeap_tb.sv
//----------------------------------------------------------------------
// Testbench of the array heap: sends requests under credit control,
// predicts each response and checks it with concurrent assertions
//----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module arrayHeap_tb;
  import heapPkg::*;

  localparam int ARRAYS        = 4;
  localparam int ARRAY_LENGTH  = 4;
  localparam int QUEUE_DEPTH   = 4;
  localparam int REQUEST_COUNT = 60;              // Requests sent over all tests

  logic        clock;
  logic        reset;
  logic        reqValid;
  heapAction_t reqAction;
  logic [1:0]  reqArray;
  logic [1:0]  reqIndex;
  logic [11:0] reqData;
  logic        reqCredit;
  logic        respValid;
  logic [11:0] respData;
  heapError_t  respError;
  logic        respCredit;

  integer      seed = 32'h0116_d19d;
  int          reqCredits;                        // Request credits we hold
  int          creditsOut;                        // Granted, not yet used by the heap
  int          withholdCycles;                    // Back-pressure stretch
  logic [11:0] expData;                           // Head of expected responses
  heapError_t  expError;
  logic [11:0] expDataQ [$];
  heapError_t  expErrorQ [$];

  // Reference model state
  logic [11:0] modelMem [ARRAYS][ARRAY_LENGTH];
  int          modelSize [ARRAYS];
  bit          modelLive [ARRAYS];
  int          freeList [$];
  int          freshCount;

  arrayHeap u_dut (
    .clock      (clock),
    .reset      (reset),
    .reqValid   (reqValid),
    .reqAction  (reqAction),
    .reqArray   (reqArray),
    .reqIndex   (reqIndex),
    .reqData    (reqData),
    .reqCredit  (reqCredit),
    .respValid  (respValid),
    .respData   (respData),
    .respError  (respError),
    .respCredit (respCredit)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;                    // 4 ns period
  end

  task automatic stopRun();
    $display("Test FAILED");
    $fatal(1);
  endtask

  //----------------------------------------------------------------------
  // Response checks against the expected head
  //----------------------------------------------------------------------
  dataCheck: assert property (@(posedge clock) disable iff (!reset)
    respValid |-> respData == expData)
    else begin
      $display("[FAIL] %0t ns respData expected %h actual %h", $time, expData,
               $sampled(respData));
      stopRun();
    end

  errorCheck: assert property (@(posedge clock) disable iff (!reset)
    respValid |-> respError == expError)
    else begin
      $display("[FAIL] %0t ns respError expected %0d actual %0d", $time, expError,
               $sampled(respError));
      stopRun();
    end

  // Steps to the next falling edge and collects credits and the expected head
  task automatic nextEdge();
    @(negedge clock);
    if (u_dut.u_assertions.failCount != 0) begin
      $display("A protocol assertion on the heap ports failed");
      stopRun();
    end
    if (reqCredit) reqCredits++;
    if (respValid) begin
      if (expDataQ.size() == 0) begin
        $display("Response arrived with no request outstanding");
        stopRun();
      end else begin
        expData  = expDataQ.pop_front();
        expError = expErrorQ.pop_front();
        creditsOut--;
      end
    end
    reqValid   = 1'b0;
    respCredit = 1'b0;
    if (withholdCycles > 0) withholdCycles--;     // Consumer stalled
    else if (creditsOut < 2 && $random(seed) % 2 != 0) begin
      respCredit = 1'b1;
      creditsOut++;
    end
  endtask

  // Reference model updated when the request is sent
  task automatic predict(input heapAction_t action, input int a, input int i,
                         input logic [11:0] d, output logic [11:0] expD,
                         output heapError_t expE);
    int n;
    expD = '0;
    expE = errNone;
    n    = -1;
    if (action == actAlloc) begin
      if (freeList.size() != 0) n = freeList.pop_back();   // Freed numbers first
      else if (freshCount < ARRAYS) begin
        n = freshCount;
        freshCount++;
      end
      if (n < 0) expE = errNoSpace;
      else begin
        modelLive[n] = 1'b1;
        modelSize[n] = 0;
        expD         = 12'(n);
      end
    end else if (!modelLive[a]) begin
      expE = errNotAllocated;                     // No effect on state
    end else begin
      case (action)
        actFree: begin
          modelLive[a] = 1'b0;
          modelSize[a] = 0;
          freeList.push_back(a);
          expD = 12'(a);
        end
        actWrite: begin
          modelMem[a][i] = d;
          if (modelSize[a] <= i) modelSize[a] = i + 1;
          expD = d;
        end
        actRead: begin
          if (i >= modelSize[a]) expE = errOutOfBounds;
          else expD = modelMem[a][i];
        end
        actSize: expD = 12'(modelSize[a]);
        actPush: begin
          if (modelSize[a] == ARRAY_LENGTH) expE = errFull;
          else begin
            modelMem[a][modelSize[a]] = d;
            modelSize[a]++;
            expD = d;
          end
        end
        actPop: begin
          if (modelSize[a] == 0) expE = errEmpty;
          else begin
            modelSize[a]--;
            expD = modelMem[a][modelSize[a]];
          end
        end
        actAdd: begin
          if (i >= modelSize[a]) expE = errOutOfBounds;
          else begin
            modelMem[a][i] = modelMem[a][i] + d;  // Wraps at 12 bits
            expD = modelMem[a][i];
          end
        end
        default: ;
      endcase
    end
  endtask

  // Waits for a request credit, then drives one request for one cycle
  task automatic sendRequest(input heapAction_t action, input int a, input int i,
                             input int d);
    logic [11:0] expD;
    heapError_t  expE;
    nextEdge();
    while (reqCredits == 0) nextEdge();
    reqValid  = 1'b1;
    reqAction = action;
    reqArray  = a[1:0];
    reqIndex  = i[1:0];
    reqData   = d[11:0];
    reqCredits--;
    predict(action, a, i, d[11:0], expD, expE);
    expDataQ.push_back(expD);
    expErrorQ.push_back(expE);
  endtask

  initial begin
    #(REQUEST_COUNT * 40 + 400);
    $display("Timeout: the heap stopped answering before all responses arrived");
    stopRun();
  end

  //----------------------------------------------------------------------
  // Test sequence
  //----------------------------------------------------------------------
  initial begin
    reset          = 1'b0;
    reqValid       = 1'b0;
    reqAction      = actNone;
    reqArray       = '0;
    reqIndex       = '0;
    reqData        = '0;
    respCredit     = 1'b0;
    reqCredits     = QUEUE_DEPTH;
    creditsOut     = 0;
    withholdCycles = 0;
    expData        = '0;
    expError       = errNone;
    freshCount     = 0;
    for (int k = 0; k < ARRAYS; k++) begin
      modelSize[k] = 0;
      modelLive[k] = 1'b0;
    end
    repeat (2) @(posedge clock);
    @(negedge clock) reset = 1'b1;

    repeat (5) sendRequest(actAlloc, 0, 0, 0);    // Numbers 0..3 and then no space
    sendRequest(actFree, 1, 0, 0);
    sendRequest(actAlloc, 0, 0, 0);               // Reuses 1
    sendRequest(actFree, 2, 0, 0);
    sendRequest(actFree, 2, 0, 0);                // Double free
    sendRequest(actAlloc, 0, 0, 0);

    repeat (5) sendRequest(actPush, 0, 0, $random(seed));   // Last one full
    repeat (5) sendRequest(actPop, 0, 0, 0);                 // Last one empty

    sendRequest(actRead, 0, 3, 0);                // Out of bounds on an empty array
    repeat (6) sendRequest(actWrite, 0, $random(seed) & 3, $random(seed));
    sendRequest(actSize, 0, 0, 0);
    for (int k = 0; k < ARRAY_LENGTH; k++) sendRequest(actRead, 0, k, 0);

    sendRequest(actFree, 3, 0, 0);                // Accesses to a freed array
    sendRequest(actWrite, 3, 1, $random(seed));
    sendRequest(actRead, 3, 1, 0);
    sendRequest(actPush, 3, 0, $random(seed));
    sendRequest(actSize, 3, 0, 0);
    sendRequest(actAlloc, 0, 0, 0);
    sendRequest(actSize, 3, 0, 0);

    sendRequest(actWrite, 0, 3, $random(seed));   // Whole array in bounds
    for (int k = 0; k < ARRAY_LENGTH; k++) begin
      sendRequest(actAdd, 0, k, $random(seed));
      sendRequest(actRead, 0, k, 0);
    end

    withholdCycles = 30;                          // Consumer stalls until the queue fills
    repeat (12) sendRequest(heapAction_t'(3 + $unsigned($random(seed)) % 6), 0,
                            $random(seed) & 3, $random(seed));

    while (expDataQ.size() != 0) nextEdge();
    nextEdge();                                   // Last check and credit return
    nextEdge();
    if (reqCredits == QUEUE_DEPTH) begin
      $display("Test OK");
      $finish;
    end else begin
      $display("Request credits not all returned: %0d held", reqCredits);
      stopRun();
    end
  end
endmodule

`default_nettype wire

// File: arrayHeap_assertions.sv
//----------------------------------------------------------------------
// Protocol checks on the heap's credit ports, bound into every
// arrayHeap instance
//----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module arrayHeap_assertions #(
  parameter int QUEUE_DEPTH = 4                   // Response queue slots
) (
  input logic                clock,
  input logic                reset,               // Active low
  input logic                reqValid,
  input logic                reqCredit,
  input logic                respValid,
  input logic                respCredit,
  input heapPkg::heapError_t respError
);
  int   respCredits;                              // Response credits held by the heap
  int   outstanding;                              // Requests not yet credited back
  logic settled;                                  // Low through the first cycle after reset
  int   failCount;                                // Failed assertions so far

  initial failCount = 0;

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      respCredits <= 0;
      outstanding <= 0;
      settled     <= 1'b0;
    end else begin
      respCredits <= respCredits + int'(respCredit) - int'(respValid);
      outstanding <= outstanding + int'(reqValid) - int'(reqCredit);
      settled     <= 1'b1;
    end
  end

  respNeedsCredit: assert property (@(posedge clock) disable iff (!reset)
    respValid |-> respCredits > 0)
    else begin failCount++; $error("respValid without a response credit"); end

  outstandingBound: assert property (@(posedge clock) disable iff (!reset)
    outstanding <= QUEUE_DEPTH)
    else begin failCount++; $error("more requests in flight than queue slots"); end

  quietAfterReset: assert property (@(posedge clock)
    (!reset || !settled) |-> (!respValid && !reqCredit))
    else begin failCount++; $error("response port active during or just after reset"); end

  knownError: assert property (@(posedge clock) disable iff (!reset)
    !$isunknown(respError))
    else begin failCount++; $error("respError holds an unknown value"); end
endmodule

bind arrayHeap arrayHeap_assertions #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_assertions (
  .clock      (clock),
  .reset      (reset),
  .reqValid   (reqValid),
  .reqCredit  (reqCredit),
  .respValid  (respValid),
  .respCredit (respCredit),
  .respError  (respError)
);

`default_nettype wire

// File: arrayHeap.sv
//--------------------------------------------------------------------
// Heap of fixed-length arrays with allocation. Requests and responses
// move under credit flow control on plain ports
//--------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module arrayHeap #(
  parameter int ADDRESS_BITS = 2,                 // Width of an array number
  parameter int INDEX_BITS   = 2,                 // Width of an element index
  parameter int DATA_BITS    = 12,                // Width of an element
  parameter int QUEUE_DEPTH  = 4                  // Response queue slots
) (
  input  logic                    clock,
  input  logic                    reset,          // Active low
  input  logic                    reqValid,
  input  heapPkg::heapAction_t    reqAction,
  input  logic [ADDRESS_BITS-1:0] reqArray,
  input  logic [INDEX_BITS-1:0]   reqIndex,
  input  logic [DATA_BITS-1:0]    reqData,
  output logic                    reqCredit,
  output logic                    respValid,
  output logic [DATA_BITS-1:0]    respData,
  output heapPkg::heapError_t     respError,
  input  logic                    respCredit
);

  logic arrayLive;                                // Allocator to store

  stageResultIf #(.DATA_BITS(DATA_BITS)) allocResult ();
  stageResultIf #(.DATA_BITS(DATA_BITS)) storeResult ();

  arrayAllocator #(
    .ADDRESS_BITS (ADDRESS_BITS),
    .DATA_BITS    (DATA_BITS)
  ) u_allocator (
    .clock       (clock),
    .reset       (reset),
    .reqValid    (reqValid),
    .reqAction   (reqAction),
    .reqArray    (reqArray),
    .arrayLive   (arrayLive),
    .allocResult (allocResult.source)
  );

  arrayStore #(
    .ADDRESS_BITS (ADDRESS_BITS),
    .INDEX_BITS   (INDEX_BITS),
    .DATA_BITS    (DATA_BITS)
  ) u_store (
    .clock       (clock),
    .reset       (reset),
    .reqValid    (reqValid),
    .reqAction   (reqAction),
    .reqArray    (reqArray),
    .reqIndex    (reqIndex),
    .reqData     (reqData),
    .arrayLive   (arrayLive),
    .storeResult (storeResult.source)
  );

  responseMerge #(
    .DATA_BITS   (DATA_BITS),
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_merge (
    .clock       (clock),
    .reset       (reset),
    .allocResult (allocResult.sink),
    .storeResult (storeResult.sink),
    .respCredit  (respCredit),
    .reqCredit   (reqCredit),
    .respValid   (respValid),
    .respData    (respData),
    .respError   (respError)
  );
endmodule

`default_nettype wire

// File: responseMerge.sv
//--------------------------------------------------------------------
// Merges the allocator and store results into one response, queues
// it and runs the request and response credit counts
//--------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module responseMerge #(
  parameter int DATA_BITS   = 12,                 // Width of the response word
  parameter int QUEUE_DEPTH = 4                   // Response queue slots
) (
  input  logic                  clock,
  input  logic                  reset,            // Active low
  stageResultIf.sink            allocResult,
  stageResultIf.sink            storeResult,
  input  logic                  respCredit,       // One credit per pulse
  output logic                  reqCredit,        // One credit back per pop
  output logic                  respValid,
  output logic [DATA_BITS-1:0]  respData,
  output heapPkg::heapError_t   respError
);
  import heapPkg::*;

  localparam int PTR_BITS    = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int COUNT_BITS  = $clog2(QUEUE_DEPTH + 1);
  localparam int CREDIT_BITS = 16;                // Room for a generous consumer

  logic [DATA_BITS-1:0]  dataQueue  [QUEUE_DEPTH];
  heapError_t            errorQueue [QUEUE_DEPTH];
  logic [PTR_BITS-1:0]   headPtr;
  logic [PTR_BITS-1:0]   tailPtr;
  logic [COUNT_BITS-1:0] queueCount;
  logic [CREDIT_BITS-1:0] creditCount;            // Response credits held

  logic                  pushEntry;
  logic                  fromAllocator;
  heapError_t            mergedError;
  logic [DATA_BITS-1:0]  mergedData;

  function automatic logic [PTR_BITS-1:0] nextPtr(input logic [PTR_BITS-1:0] ptr);
    if (ptr == PTR_BITS'(QUEUE_DEPTH - 1)) return '0;
    return ptr + 1'b1;
  endfunction

  //--------------------------------------------------------------------
  // Merge with the allocator error first
  //--------------------------------------------------------------------
  assign pushEntry     = allocResult.valid && storeResult.valid;  // Always together
  assign fromAllocator = (allocResult.action == actAlloc) || (allocResult.action == actFree);
  assign mergedError   = (allocResult.error != errNone) ? allocResult.error : storeResult.error;
  assign mergedData    = (mergedError != errNone) ? '0
                       : fromAllocator ? allocResult.data : storeResult.data;

  // Send only with something queued and a credit held
  assign respValid = (queueCount != '0) && (creditCount != '0);
  assign respData  = respValid ? dataQueue[headPtr] : '0;
  assign respError = respValid ? errorQueue[headPtr] : errNone;

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      headPtr     <= '0;
      tailPtr     <= '0;
      queueCount  <= '0;
      creditCount <= '0;
      reqCredit   <= 1'b0;
    end else begin
      reqCredit <= respValid;                     // Slot already free by now
      if (pushEntry) tailPtr <= nextPtr(tailPtr);
      if (respValid) headPtr <= nextPtr(headPtr);
      case ({pushEntry, respValid})
        2'b10:   queueCount <= queueCount + 1'b1;
        2'b01:   queueCount <= queueCount - 1'b1;
        default: ;                                // Both or neither
      endcase
      case ({respCredit, respValid})
        2'b10:   creditCount <= creditCount + 1'b1;
        2'b01:   creditCount <= creditCount - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (pushEntry) begin
      dataQueue[tailPtr]  <= mergedData;
      errorQueue[tailPtr] <= mergedError;
    end
  end
endmodule

`default_nettype wire

// File: arrayStore.sv
//--------------------------------------------------------------------
// Element memory and per-array sizes; carries out the element
// operations on live arrays and registers the result
//--------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module arrayStore #(
  parameter int ADDRESS_BITS = 2,                 // Width of an array number
  parameter int INDEX_BITS   = 2,                 // Width of an element index
  parameter int DATA_BITS    = 12                 // Width of an element
) (
  input  logic                    clock,
  input  logic                    reset,          // Active low
  input  logic                    reqValid,
  input  heapPkg::heapAction_t    reqAction,
  input  logic [ADDRESS_BITS-1:0] reqArray,
  input  logic [INDEX_BITS-1:0]   reqIndex,
  input  logic [DATA_BITS-1:0]    reqData,
  input  logic                    arrayLive,      // From the allocator
  stageResultIf.source            storeResult
);
  import heapPkg::*;

  localparam int ARRAY_LENGTH = 2 ** INDEX_BITS;
  localparam int ARRAYS       = 2 ** ADDRESS_BITS;

  logic [DATA_BITS-1:0]  memory [ARRAYS][ARRAY_LENGTH];  // Fixed block per array
  logic [INDEX_BITS:0]   sizes  [ARRAYS];                // Zero after reset or free

  logic [INDEX_BITS:0]   curSize;
  logic [INDEX_BITS:0]   indexPlusOne;
  logic [INDEX_BITS:0]   sizeLess;
  logic                  outOfBounds;
  logic                  isFull;
  logic [DATA_BITS-1:0]  element;
  logic [DATA_BITS-1:0]  topElement;
  logic [DATA_BITS-1:0]  addSum;
  logic                  commit;                  // Update only live arrays

  logic                  memWrite;
  logic [INDEX_BITS-1:0] memIndex;
  logic [DATA_BITS-1:0]  memValue;
  logic                  sizeWrite;
  logic [INDEX_BITS:0]   sizeValue;
  logic [DATA_BITS-1:0]  resultData;
  heapError_t            resultError;

  assign curSize      = sizes[reqArray];
  assign indexPlusOne = {1'b0, reqIndex} + 1'b1;
  assign sizeLess     = curSize - 1'b1;
  assign outOfBounds  = {1'b0, reqIndex} >= curSize;
  assign isFull       = curSize[INDEX_BITS];      // Size never exceeds ARRAY_LENGTH
  assign element      = memory[reqArray][reqIndex];
  assign topElement   = memory[reqArray][sizeLess[INDEX_BITS-1:0]];
  assign addSum       = element + reqData;        // Wraps at DATA_BITS
  assign commit       = reqValid && arrayLive;

  //--------------------------------------------------------------------
  // Decode of the element operations
  //--------------------------------------------------------------------
  always_comb begin
    memWrite    = 1'b0;
    memIndex    = reqIndex;
    memValue    = reqData;
    sizeWrite   = 1'b0;
    sizeValue   = curSize;
    resultData  = '0;
    resultError = errNone;
    case (reqAction)
      actWrite: begin
        memWrite   = 1'b1;
        sizeWrite  = outOfBounds;                 // Grow to cover the index
        sizeValue  = indexPlusOne;
        resultData = reqData;
      end
      actRead: begin
        if (outOfBounds) resultError = errOutOfBounds;
        else resultData = element;
      end
      actSize: resultData = DATA_BITS'(curSize);
      actPush: begin
        if (isFull) begin
          resultError = errFull;
        end else begin
          memWrite   = 1'b1;
          memIndex   = curSize[INDEX_BITS-1:0];
          sizeWrite  = 1'b1;
          sizeValue  = curSize + 1'b1;            // Size plus one
          resultData = reqData;
        end
      end
      actPop: begin
        if (curSize == '0) begin
          resultError = errEmpty;
        end else begin
          sizeWrite  = 1'b1;
          sizeValue  = sizeLess;
          resultData = topElement;
        end
      end
      actAdd: begin
        if (outOfBounds) begin
          resultError = errOutOfBounds;
        end else begin
          memWrite   = 1'b1;
          memValue   = addSum;
          resultData = addSum;
        end
      end
      actFree: begin                              // Next owner starts empty
        sizeWrite = 1'b1;
        sizeValue = '0;
      end
      default: ;                                  // Alloc needs nothing here
    endcase
  end

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      for (int i = 0; i < ARRAYS; i++) sizes[i] <= '0;
      storeResult.valid <= 1'b0;
    end else begin
      storeResult.valid <= reqValid;
      if (commit && sizeWrite) sizes[reqArray] <= sizeValue;
    end
  end

  always_ff @(posedge clock) begin
    if (commit && memWrite) memory[reqArray][memIndex] <= memValue;
    if (reqValid) begin
      storeResult.action <= reqAction;
      storeResult.data   <= resultData;
      storeResult.error  <= resultError;
    end
  end
endmodule

`default_nettype wire

// File: arrayAllocator.sv
//--------------------------------------------------------------------
// Allocation table of the heap: hands out array numbers, takes them
// back on free and tells the element store which arrays are live
//--------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module arrayAllocator #(
  parameter int ADDRESS_BITS = 2,                 // Width of an array number
  parameter int DATA_BITS    = 12               // Width of the result word
) (
  input  logic                    clock,
  input  logic                    reset,          // Active low
  input  logic                    reqValid,
  input  heapPkg::heapAction_t    reqAction,
  input  logic [ADDRESS_BITS-1:0] reqArray,
  output logic                    arrayLive,      // Requested array is allocated
  stageResultIf.source            allocResult
);
  import heapPkg::*;

  localparam int ARRAYS = 2 ** ADDRESS_BITS;

  logic [ARRAYS-1:0]       allocated;             // One flag per array
  logic [ADDRESS_BITS-1:0] freeStack [ARRAYS];    // Freed numbers, reused first
  logic [ADDRESS_BITS:0]   freeTop;               // Entries on the free stack
  logic [ADDRESS_BITS:0]   freshCount;            // Arrays ever handed out
  logic [ADDRESS_BITS:0]   popSlot;
  logic [ADDRESS_BITS-1:0] newArray;              // Number an Alloc would get
  logic                    canAlloc;
  logic                    doAlloc;
  logic                    doFree;

  // Table as it stands before this request
  assign arrayLive = allocated[reqArray];
  assign popSlot   = freeTop - 1'b1;
  assign canAlloc  = (freeTop != '0) || !freshCount[ADDRESS_BITS];  // Top bit set once all used
  assign newArray  = (freeTop != '0) ? freeStack[popSlot[ADDRESS_BITS-1:0]]
                                     : freshCount[ADDRESS_BITS-1:0];
  assign doAlloc   = reqValid && (reqAction == actAlloc) && canAlloc;
  assign doFree    = reqValid && (reqAction == actFree) && arrayLive;

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      allocated         <= '0;
      freeTop           <= '0;
      freshCount        <= '0;
      allocResult.valid <= 1'b0;
    end else begin
      allocResult.valid <= reqValid;
      if (doAlloc) begin
        allocated[newArray] <= 1'b1;
        if (freeTop != '0) freeTop <= popSlot;    // Reuse a freed number
        else freshCount <= freshCount + 1'b1;     // Otherwise a fresh one
      end
      if (doFree) begin
        allocated[reqArray] <= 1'b0;
        freeTop             <= freeTop + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (doFree) freeStack[freeTop[ADDRESS_BITS-1:0]] <= reqArray;  // Cannot overflow
    if (reqValid) begin
      allocResult.action <= reqAction;
      if (reqAction == actAlloc) begin
        allocResult.data  <= DATA_BITS'(newArray);
        allocResult.error <= canAlloc ? errNone : errNoSpace;
      end else begin
        allocResult.data  <= DATA_BITS'(reqArray); // Freed number for Free
        allocResult.error <= arrayLive ? errNone : errNotAllocated;
      end
    end
  end
endmodule

`default_nettype wire

// File: stageResultIf.sv
//--------------------------------------------------------------------
// One registered stage result, passed from a side unit to the
// response merger
//--------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

interface stageResultIf #(
  parameter int DATA_BITS = 12          // Width of the result word
) ();
  import heapPkg::*;

  logic                 valid;          // Result present this cycle
  heapAction_t          action;         // Operation that produced it
  logic [DATA_BITS-1:0] data;           // Result word
  heapError_t           error;          // Error seen by this unit

  modport source (output valid, action, data, error);
  modport sink   (input  valid, action, data, error);
endinterface

`default_nettype wire

// File: heapPkg.sv
//--------------------------------------------------------------------
// Shared types of the array heap: the requested operation and the
// error code carried back with every response
//--------------------------------------------------------------------
`default_nettype none

package heapPkg;

  //--------------------------------------------------------------------
  // Requested operation
  //--------------------------------------------------------------------
  typedef enum logic [3:0] {
    actNone  = 4'd0,                    // Idle slot
    actAlloc = 4'd1,                    // Allocate an array, returns its number
    actFree  = 4'd2,                    // Release an array for reuse
    actWrite = 4'd3,                    // Store one element
    actRead  = 4'd4,                    // Fetch one element
    actSize  = 4'd5,                    // Current element count
    actPush  = 4'd6,                    // Append at the end
    actPop   = 4'd7,                    // Remove from the end
    actAdd   = 4'd8                     // Add in place, returns new value
  } heapAction_t;

  //--------------------------------------------------------------------
  // Response error code
  //--------------------------------------------------------------------
  typedef enum logic [2:0] {
    errNone         = 3'd0,             // Request carried out
    errNotAllocated = 3'd1,             // Never handed out or already freed
    errOutOfBounds  = 3'd2,             // Index at or past the size
    errFull         = 3'd3,             // Push onto a full array
    errEmpty        = 3'd4,             // Pop from an empty array
    errNoSpace      = 3'd5              // Heap exhausted
  } heapError_t;

endpackage

`default_nettype wire
